// ==== list.f ====
verilog/ising_pkg.sv
verilog/weight_prefetch_fifo.sv
verilog/local_field_unit.sv
verilog/energy_monitor.sv
verilog/flip_manager.sv
verilog/digital_macro.sv
testbench/tb_memory_models.sv
testbench/digital_macro_assertions.sv
testbench/tb_digital_macro.sv

// ==== testbench/digital_macro_assertions.sv ====
// digital_macro_assertions: concurrent protocol checks on the top level, bound to digital_macro
`timescale 1ns/1ps

module digital_macro_assertions
    import ising_pkg::*;
(
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     eval_valid_o,
    input logic                     cmpt_idle_o,
    input flip_req_t                flip_req_o,
    input logic [FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i
);

    // eval is a single-cycle pulse
    eval_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eval_valid_o |=> !eval_valid_o)
        else $error("eval_valid_o high on two consecutive cycles");

    flip_idle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flip_req_o.ren |-> !cmpt_idle_o)
        else $error("flip read issued while idle");

    flip_addr_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flip_req_o.ren |-> (flip_req_o.raddr < icon_last_raddr_plus_one_i))
        else $error("flip read address beyond last icon");

endmodule

bind digital_macro digital_macro_assertions u_assertions (.*);

// ==== testbench/digital_macro_trace.txt ====
// one hex word per line: [0] scaling, [1] h, [2..9] J words, [10..17] flip icons,
// [18] run count, then runs: spin, icon_last, en_comparison, energies, best spin, best energy
2
0000000000D00001
00000000000000030000000000000030
0000000000000E00000000000000E000
00000000000000000000000000010000
0
0
0
0
0
0001
0002
0004
0020
0008
0003
0010
0021
3
// run 0: comparison on
0000
4
1
00000007
FFFFFFFF
0000000B
00000007
FFFFFFF3
0021
FFFFFFF3
// run 1: comparison off
00F0
3
0
FFFFFFFB
FFFFFFF3
FFFFFFFF
00000007
00F7
00000007
// run 2: candidate 0 only
0003
0
1
0000000B
0003
0000000B

// ==== testbench/tb_digital_macro.sv ====
// tb_digital_macro: clock, reset, trace loading, search runs, flush rerun and result checks
`timescale 1ns/1ps

module tb_digital_macro;
    import ising_pkg::*;

    localparam int TIMEOUT   = 2000;
    localparam int H_IDX     = 1;
    localparam int J_IDX     = 2;
    localparam int ICON_IDX  = 10;
    localparam int NRUN_IDX  = 18;
    localparam int RUN_IDX   = 19;

    logic                     clk_i = 1'b0;
    logic                     rst_n_i;
    logic                     config_valid_i;
    spin_t                    config_spin_i;
    logic                     en_comparison_i;
    logic [FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i;
    hbias_t                   hbias_i;
    logic [SCALING_BIT-1:0]   hscaling_i;
    logic                     cmpt_en_i;
    logic                     flush_i;
    weight_req_t              weight_req_o;
    weight_word_t             weight_rdata_i;
    flip_req_t                flip_req_o;
    spin_t                    flip_rdata_i;
    logic                     cmpt_idle_o;
    logic                     eval_valid_o;
    spin_energy_t             eval_o;
    spin_energy_t             best_o;

    logic [127:0] trace_mem [64];
    int           mismatch_errors = 0;
    int           timeout_errors = 0;

    always #5 clk_i = ~clk_i;

    digital_macro uut (.*);

    tb_memory_models u_mem (
        .clk_i          (clk_i),
        .weight_req_i   (weight_req_o),
        .weight_rdata_o (weight_rdata_i),
        .flip_req_i     (flip_req_o),
        .flip_rdata_o   (flip_rdata_i)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_eval(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk_i);
            seen = eval_valid_o;
            cycles++;
        end
        assert (seen) else begin
            timeout_errors++;
            $error("timeout waiting for eval_valid_o after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk_i);
            seen = cmpt_idle_o;
            cycles++;
        end
        assert (seen) else begin
            timeout_errors++;
            $error("timeout waiting for cmpt_idle_o after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic configure(input spin_t spin);
        @(posedge clk_i);
        #1;
        config_spin_i  = spin;
        config_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        config_valid_i = 1'b0;
    endtask

    // levels first, then a one-cycle rising edge on cmpt_en_i
    task automatic start_run(input int last, input bit cmp);
        @(posedge clk_i);
        #1;
        icon_last_raddr_plus_one_i = FLIP_ADDR_BIT'(last);
        en_comparison_i            = cmp;
        cmpt_en_i                  = 1'b1;
        @(posedge clk_i);
        #1;
        cmpt_en_i = 1'b0;
    endtask

    task automatic run_and_check(input int base, output int next_base);
        spin_t   cfg;
        spin_t   best_spin;
        spin_t   exp_spin;
        energy_t best_e;
        energy_t exp_e;
        int      last;
        bit      cmp;
        bit      seen;
        cfg       = trace_mem[base][15:0];
        last      = int'(trace_mem[base+1][7:0]);
        cmp       = trace_mem[base+2][0];
        best_spin = cfg;
        best_e    = '0;
        configure(cfg);
        start_run(last, cmp);
        for (int k = 0; k <= last; k++) begin
            wait_eval(seen);
            if (!seen) begin
                break;
            end
            exp_spin = (k == 0) ? cfg : best_spin ^ trace_mem[ICON_IDX+k-1][15:0];
            exp_e    = trace_mem[base+3+k][31:0];
            check_value("eval_o.spin", 32'(eval_o.spin), 32'(exp_spin));
            check_value("eval_o.energy", eval_o.energy, exp_e);
            // selection rule
            if (k == 0 || !cmp || exp_e < best_e) begin
                best_spin = exp_spin;
                best_e    = exp_e;
            end
        end
        wait_idle();
        check_value("best_o.spin", 32'(best_o.spin), trace_mem[base+4+last][31:0]);
        check_value("best_o.energy", best_o.energy, trace_mem[base+5+last][31:0]);
        check_value("best_o.spin", 32'(best_o.spin), 32'(best_spin));
        next_base = base + 6 + last;
    endtask

    initial begin
        int  base;
        int  next_base;
        int  run_count;
        bit  seen;
        void'($urandom(32'h5a92_ec3f));
        rst_n_i                    = 1'b0;
        config_valid_i             = 1'b0;
        config_spin_i              = '0;
        en_comparison_i            = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        hbias_i                    = '0;
        hscaling_i                 = '0;
        cmpt_en_i                  = 1'b0;
        flush_i                    = 1'b0;

        $readmemh("testbench/digital_macro_trace.txt", trace_mem);
        hscaling_i = trace_mem[0][SCALING_BIT-1:0];
        hbias_i    = trace_mem[H_IDX][NUM_SPIN*BITH-1:0];
        for (int i = 0; i < J_ROWS; i++) begin
            u_mem.weight_mem[i] = trace_mem[J_IDX+i];
        end
        // unused icon slots get an address-dependent pattern
        for (int i = 0; i < 2**FLIP_ADDR_BIT; i++) begin
            u_mem.flip_mem[i] = 16'hc3a0 ^ (16'(i) * 16'h0101);
        end
        for (int i = 0; i < 8; i++) begin
            u_mem.flip_mem[i] = trace_mem[ICON_IDX+i][15:0];
        end

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        @(negedge clk_i);
        check_value("cmpt_idle_o", 32'(cmpt_idle_o), 32'd1);
        check_value("eval_valid_o", 32'(eval_valid_o), 32'd0);
        check_value("flip_req_o.ren", 32'(flip_req_o.ren), 32'd0);
        check_value("weight_req_o.ren", 32'(weight_req_o.ren), 32'd0);
        check_value("best_o.spin", 32'(best_o.spin), 32'd0);
        check_value("best_o.energy", best_o.energy, 32'd0);

        // prefetch begins one cycle after reset release, at row pair 0
        @(negedge clk_i);
        check_value("weight_req_o.ren", 32'(weight_req_o.ren), 32'd1);
        check_value("weight_req_o.raddr", 32'(weight_req_o.raddr), 32'd0);

        run_count = int'(trace_mem[NRUN_IDX][7:0]);
        base = RUN_IDX;
        for (int r = 0; r < run_count; r++) begin
            run_and_check(base, next_base);
            base = next_base;
            repeat ($urandom_range(3)) @(posedge clk_i);
        end

        // abort the first run part way, then repeat it
        configure(trace_mem[RUN_IDX][15:0]);
        start_run(int'(trace_mem[RUN_IDX+1][7:0]), trace_mem[RUN_IDX+2][0]);
        wait_eval(seen);
        wait_eval(seen);
        @(posedge clk_i);
        #1;
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        // idle within one cycle of the flush
        @(negedge clk_i);
        check_value("cmpt_idle_o", 32'(cmpt_idle_o), 32'd1);
        repeat ($urandom_range(3)) @(posedge clk_i);
        run_and_check(RUN_IDX, next_base);

        repeat (4) @(posedge clk_i);
        $display("error counts: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_memory_models.sv ====
// tb_memory_models: weight and flip memories with one-cycle read latency
`timescale 1ns/1ps

module tb_memory_models
    import ising_pkg::*;
(
    input  logic         clk_i,
    input  weight_req_t  weight_req_i,
    output weight_word_t weight_rdata_o,
    input  flip_req_t    flip_req_i,
    output spin_t        flip_rdata_o
);

    // filled by the testbench through hierarchical access
    weight_word_t weight_mem [J_ROWS];
    spin_t        flip_mem [2**FLIP_ADDR_BIT];

    initial begin
        weight_rdata_o = '0;
        flip_rdata_o   = '0;
    end

    always @(posedge clk_i) begin
        if (weight_req_i.ren) begin
            weight_rdata_o <= weight_mem[weight_req_i.raddr];
        end
        if (flip_req_i.ren) begin
            flip_rdata_o <= flip_mem[flip_req_i.raddr];
        end
    end

endmodule

// ==== verilog/digital_macro.sv ====
// digital_macro: top level over weight prefetch FIFO, energy monitor and flip manager
`timescale 1ns/1ps

module digital_macro
    import ising_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     config_valid_i,
    input  spin_t                    config_spin_i,
    input  logic                     en_comparison_i,
    input  logic [FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    input  hbias_t                   hbias_i,
    input  logic [SCALING_BIT-1:0]   hscaling_i,
    input  logic                     cmpt_en_i,
    input  logic                     flush_i,
    output weight_req_t              weight_req_o,
    input  weight_word_t             weight_rdata_i,
    output flip_req_t                flip_req_o,
    input  spin_t                    flip_rdata_i,
    output logic                     cmpt_idle_o,
    output logic                     eval_valid_o,
    output spin_energy_t             eval_o,
    output spin_energy_t             best_o
);

    logic         weight_valid;
    weight_word_t weight_data;
    logic         weight_ready;
    logic         cand_valid;
    spin_t        cand_spin;
    logic         cand_ready;
    logic         result_valid;
    spin_energy_t result;
    logic         result_ready;

    weight_prefetch_fifo u_weight_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .weight_req_o   (weight_req_o),
        .weight_rdata_i (weight_rdata_i),
        .weight_valid_o (weight_valid),
        .weight_data_o  (weight_data),
        .weight_ready_i (weight_ready)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .spin_valid_i   (cand_valid),
        .spin_i         (cand_spin),
        .spin_ready_o   (cand_ready),
        .weight_valid_i (weight_valid),
        .weight_i       (weight_data),
        .weight_ready_o (weight_ready),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .result_valid_o (result_valid),
        .result_o       (result),
        .result_ready_i (result_ready)
    );

    flip_manager u_flip_manager (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .flush_i                    (flush_i),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .config_valid_i             (config_valid_i),
        .config_spin_i              (config_spin_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_req_o                 (flip_req_o),
        .flip_rdata_i               (flip_rdata_i),
        .cand_valid_o               (cand_valid),
        .cand_spin_o                (cand_spin),
        .cand_ready_i               (cand_ready),
        .result_valid_i             (result_valid),
        .result_i                   (result),
        .result_ready_o             (result_ready),
        .cmpt_idle_o                (cmpt_idle_o),
        .eval_valid_o               (eval_valid_o),
        .eval_o                     (eval_o),
        .best_o                     (best_o)
    );

endmodule

// ==== verilog/energy_monitor.sv ====
// energy_monitor: spin accept, row-pair energy accumulation and spin/energy result handshake
`timescale 1ns/1ps

module energy_monitor
    import ising_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   spin_valid_i,
    input  spin_t                  spin_i,
    output logic                   spin_ready_o,
    input  logic                   weight_valid_i,
    input  weight_word_t           weight_i,
    output logic                   weight_ready_o,
    input  hbias_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    output logic                   result_valid_o,
    output spin_energy_t           result_o,
    input  logic                   result_ready_i
);

    em_state_e             state_q;
    spin_t                 spin_q;
    logic [J_ADDR_BIT-1:0] row_cnt_q;
    energy_t               acc_q;
    energy_t               partial;
    logic                  spin_fire;
    logic                  weight_fire;
    logic                  last_row;

    assign spin_ready_o   = (state_q == EM_IDLE);
    assign weight_ready_o = (state_q == EM_ACC);
    assign result_valid_o = (state_q == EM_DONE);
    assign result_o       = '{spin: spin_q, energy: acc_q};

    assign spin_fire   = spin_valid_i & spin_ready_o;
    assign weight_fire = weight_valid_i & weight_ready_o;
    assign last_row    = (row_cnt_q == J_ADDR_BIT'(J_ROWS - 1));

    // word index doubles as the row base since the FIFO walks rows in order
    local_field_unit u_local_field (
        .spin_i     (spin_q),
        .rows_i     (weight_i),
        .hbias_i    (hbias_i),
        .hscaling_i (hscaling_i),
        .row_base_i (row_cnt_q),
        .partial_o  (partial)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q   <= EM_IDLE;
            row_cnt_q <= '0;
        end else begin
            case (state_q)
                EM_IDLE: begin
                    if (spin_fire) begin
                        state_q   <= EM_ACC;
                        row_cnt_q <= '0;
                    end
                end
                EM_ACC: begin
                    if (weight_fire) begin
                        row_cnt_q <= row_cnt_q + 1'b1;
                        if (last_row) begin
                            state_q <= EM_DONE;
                        end
                    end
                end
                EM_DONE: begin
                    if (result_ready_i) begin
                        state_q <= EM_IDLE;
                    end
                end
                default: state_q <= EM_IDLE;
            endcase
        end
    end

    // spin and running sum
    always_ff @(posedge clk_i) begin
        if (spin_fire) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end else if (weight_fire) begin
            acc_q <= acc_q + partial;
        end
    end

endmodule

// ==== verilog/flip_manager.sv ====
// flip_manager: run control, flip icon fetch, candidates, energy selection and best register
`timescale 1ns/1ps

module flip_manager
    import ising_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     cmpt_en_i,
    input  logic                     en_comparison_i,
    input  logic                     config_valid_i,
    input  spin_t                    config_spin_i,
    input  logic [FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    output flip_req_t                flip_req_o,
    input  spin_t                    flip_rdata_i,
    output logic                     cand_valid_o,
    output spin_t                    cand_spin_o,
    input  logic                     cand_ready_i,
    input  logic                     result_valid_i,
    input  spin_energy_t             result_i,
    output logic                     result_ready_o,
    output logic                     cmpt_idle_o,
    output logic                     eval_valid_o,
    output spin_energy_t             eval_o,
    output spin_energy_t             best_o
);

    fm_state_e                state_q;
    logic                     cmpt_en_q;
    logic                     start;
    logic                     first_q;
    logic [FLIP_ADDR_BIT-1:0] icon_cnt_q;
    logic [FLIP_ADDR_BIT-1:0] last_q;
    spin_t                    cand_q;
    spin_energy_t             best_q;
    spin_energy_t             eval_q;
    logic                     eval_valid_q;
    logic                     result_fire;
    logic                     run_done;
    logic                     lower;

    assign start       = cmpt_en_i & ~cmpt_en_q;
    assign result_fire = result_valid_i & result_ready_o;
    assign run_done    = (icon_cnt_q == last_q);
    assign lower       = (result_i.energy < best_q.energy);

    assign cmpt_idle_o    = (state_q == FM_IDLE);
    assign cand_valid_o   = (state_q == FM_SEND);
    assign cand_spin_o    = cand_q;
    assign result_ready_o = (state_q == FM_WAIT);
    assign eval_valid_o   = eval_valid_q;
    assign eval_o         = eval_q;
    assign best_o         = best_q;

    // icon k is requested as soon as result k lands, data returns in FM_FETCH
    assign flip_req_o.ren   = result_fire & ~run_done & ~flush_i;
    assign flip_req_o.raddr = icon_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= FM_IDLE;
            cmpt_en_q    <= 1'b0;
            first_q      <= 1'b0;
            icon_cnt_q   <= '0;
            last_q       <= '0;
            eval_valid_q <= 1'b0;
            best_q       <= '0;
        end else begin
            cmpt_en_q    <= cmpt_en_i;
            eval_valid_q <= result_fire & ~flush_i;
            if (flush_i) begin
                // best result survives a flush
                state_q <= FM_IDLE;
            end else begin
                case (state_q)
                    FM_IDLE: begin
                        if (start) begin
                            state_q    <= FM_SEND;
                            first_q    <= 1'b1;
                            icon_cnt_q <= '0;
                            last_q     <= icon_last_raddr_plus_one_i;
                        end else if (config_valid_i) begin
                            best_q.spin <= config_spin_i;
                        end
                    end
                    FM_SEND: begin
                        if (cand_ready_i) begin
                            state_q <= FM_WAIT;
                        end
                    end
                    FM_WAIT: begin
                        if (result_valid_i) begin
                            first_q <= 1'b0;
                            // candidate 0 always wins, then strictly lower only
                            if (first_q || !en_comparison_i || lower) begin
                                best_q <= result_i;
                            end
                            state_q <= run_done ? FM_IDLE : FM_FETCH;
                        end
                    end
                    FM_FETCH: begin
                        icon_cnt_q <= icon_cnt_q + 1'b1;
                        state_q    <= FM_SEND;
                    end
                    default: state_q <= FM_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FM_IDLE && start) begin
            cand_q <= best_q.spin;
        end else if (state_q == FM_FETCH) begin
            cand_q <= best_q.spin ^ flip_rdata_i;
        end
        if (result_fire) begin
            eval_q <= result_i;
        end
    end

endmodule

// ==== verilog/ising_pkg.sv ====
// ising package: sizes, spin and energy types, weight word, request structs, FSM states
package ising_pkg;

    localparam int NUM_SPIN      = 16;
    localparam int BITJ          = 4;
    localparam int BITH          = 4;
    localparam int SCALING_BIT   = 4;
    localparam int PARALLELISM   = 2;
    localparam int ENERGY_BIT    = 32;
    localparam int J_ROWS        = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_BIT    = $clog2(J_ROWS);
    // one extra bit so the last-plus-one address fits
    localparam int FLIP_ADDR_BIT = 5;

    typedef logic [NUM_SPIN-1:0]                  spin_t;
    typedef logic signed [ENERGY_BIT-1:0]         energy_t;
    // row r at r*NUM_SPIN*BITJ, entry j at j*BITJ inside the row
    typedef logic [PARALLELISM*NUM_SPIN*BITJ-1:0] weight_word_t;
    typedef logic [NUM_SPIN*BITH-1:0]             hbias_t;

    typedef struct packed {
        spin_t   spin;
        energy_t energy;
    } spin_energy_t;

    typedef struct packed {
        logic                  ren;
        logic [J_ADDR_BIT-1:0] raddr;
    } weight_req_t;

    typedef struct packed {
        logic                     ren;
        logic [FLIP_ADDR_BIT-1:0] raddr;
    } flip_req_t;

    typedef enum logic [1:0] {
        EM_IDLE,
        EM_ACC,
        EM_DONE
    } em_state_e;

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_SEND,
        FM_WAIT,
        FM_FETCH
    } fm_state_e;

endpackage

// ==== verilog/local_field_unit.sv ====
// local_field_unit: partial energy of PARALLELISM J rows plus their scaled bias terms
`timescale 1ns/1ps

module local_field_unit
    import ising_pkg::*;
(
    input  spin_t                  spin_i,
    input  weight_word_t           rows_i,
    input  hbias_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    input  logic [J_ADDR_BIT-1:0]  row_base_i,
    output energy_t                partial_o
);

    energy_t row_term [PARALLELISM];

    for (genvar r = 0; r < PARALLELISM; r++) begin : g_row
        int      spin_idx;
        energy_t field;

        assign spin_idx = row_base_i * PARALLELISM + r;

        always_comb begin
            field = '0;
            // bit 1 is +1, bit 0 is -1
            for (int j = 0; j < NUM_SPIN; j++) begin
                if (spin_i[j]) begin
                    field = field + energy_t'(signed'(rows_i[r*NUM_SPIN*BITJ + j*BITJ +: BITJ]));
                end else begin
                    field = field - energy_t'(signed'(rows_i[r*NUM_SPIN*BITJ + j*BITJ +: BITJ]));
                end
            end
            field = field + energy_t'(signed'(hbias_i[spin_idx*BITH +: BITH]))
                          * energy_t'(hscaling_i);
        end

        assign row_term[r] = spin_i[spin_idx] ? field : -field;
    end

    always_comb begin
        partial_o = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            partial_o = partial_o + row_term[r];
        end
    end

endmodule

// ==== verilog/weight_prefetch_fifo.sv ====
// weight_prefetch_fifo: cyclic J memory reader feeding a 2-entry valid/ready FIFO
`timescale 1ns/1ps

module weight_prefetch_fifo
    import ising_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    output weight_req_t  weight_req_o,
    input  weight_word_t weight_rdata_i,
    output logic         weight_valid_o,
    output weight_word_t weight_data_o,
    input  logic         weight_ready_i
);

    weight_word_t          fifo_mem [2];
    logic                  wr_ptr_q;
    logic                  rd_ptr_q;
    logic [1:0]            count_q;
    logic [1:0]            count_d;
    logic                  pending_q;
    logic [J_ADDR_BIT-1:0] addr_q;
    weight_req_t           req_q;
    logic                  push;
    logic                  pop;
    logic                  issue;

    // read data lands one cycle after ren
    assign push    = pending_q;
    assign pop     = weight_valid_o & weight_ready_i;
    assign count_d = count_q + {1'b0, push} - {1'b0, pop};

    // entries plus reads still in flight must stay within depth
    assign issue = ({1'b0, count_d} + {2'b00, req_q.ren}) < 3'd2;

    assign weight_req_o   = req_q;
    assign weight_valid_o = (count_q != 2'd0);
    assign weight_data_o  = fifo_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            req_q     <= '0;
            pending_q <= 1'b0;
            addr_q    <= '0;
            count_q   <= 2'd0;
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
        end else begin
            req_q.ren   <= issue;
            req_q.raddr <= addr_q;
            pending_q   <= req_q.ren;
            count_q     <= count_d;
            if (issue) begin
                // wrap after the last row pair
                addr_q <= (addr_q == J_ADDR_BIT'(J_ROWS - 1)) ? '0 : addr_q + 1'b1;
            end
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= weight_rdata_i;
        end
    end

endmodule
